// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= executeCore_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/aluPkg.sv ====
`default_nettype none

package aluPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 16;
	localparam int opcodeWidth = 4;

	// Low opcode bits that pick the operation inside one unit
	localparam int funcWidth = 3;

	// Shift count taken from the bottom of operand A
	localparam int shiftWidth = 4;

	// Q2.14 result window in the 32-bit product
	localparam int fmulLow = 14;
	localparam int fmulHigh = 29;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes, top bit picks the shift and multiply unit
	////////////////////////////////////////////////////////////////////////////

	localparam logic [opcodeWidth-1:0] opAdd = 4'd0;
	localparam logic [opcodeWidth-1:0] opSub = 4'd1;
	localparam logic [opcodeWidth-1:0] opCmp = 4'd2;
	localparam logic [opcodeWidth-1:0] opCmpr = 4'd3;
	localparam logic [opcodeWidth-1:0] opAnd = 4'd4;
	localparam logic [opcodeWidth-1:0] opOr = 4'd5;
	localparam logic [opcodeWidth-1:0] opXor = 4'd6;
	localparam logic [opcodeWidth-1:0] opNot = 4'd7;
	localparam logic [opcodeWidth-1:0] opLsh = 4'd8;
	localparam logic [opcodeWidth-1:0] opRsh = 4'd9;
	localparam logic [opcodeWidth-1:0] opArsh = 4'd10;
	localparam logic [opcodeWidth-1:0] opMul = 4'd11;
	localparam logic [opcodeWidth-1:0] opFmul = 4'd12;

	// Bit positions in the registered flag word
	localparam int flagWidth = 3;
	localparam int flagZero = 0;
	localparam int flagNegative = 1;
	localparam int flagLow = 2;

endpackage

`default_nettype wire

// ==== source/arithLogicUnit.sv ====
`default_nettype none

module arithLogicUnit
(
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire [aluPkg::dataWidth-1:0] a,
	input wire [aluPkg::dataWidth-1:0] b,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic low,
	output logic negative,
	output logic zero
);

	logic [aluPkg::opcodeWidth-1:0] unitOp;
	logic signedLess;
	logic signedGreater;
	logic unsignedLess;
	logic unsignedGreater;
	logic equal;

	// Only the low bits matter here, the top bit is always clear
	assign unitOp = {1'b0, opcode[aluPkg::funcWidth-1:0]};

	assign signedLess = $signed(a) < $signed(b);
	assign signedGreater = $signed(b) < $signed(a);
	assign unsignedLess = a < b;
	assign unsignedGreater = b < a;
	assign equal = a == b;

	always_comb
	begin
		result = '0;
		low = 1'b0;
		negative = 1'b0;
		zero = 1'b0;
		case (unitOp)
			aluPkg::opAdd:
			begin
				result = a + b;
				low = signedLess;
				negative = result[aluPkg::dataWidth-1];
				zero = result == '0;
			end
			aluPkg::opSub:
			begin
				result = a - b;
				low = signedLess;
				negative = result[aluPkg::dataWidth-1];
				zero = equal;
			end
			// Compares leave the result at zero
			aluPkg::opCmp:
			begin
				low = unsignedLess;
				negative = signedLess;
				zero = equal;
			end
			aluPkg::opCmpr:
			begin
				low = unsignedGreater;
				negative = signedGreater;
				zero = equal;
			end
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor:
			begin
				if (unitOp == aluPkg::opAnd)
					result = a & b;
				else if (unitOp == aluPkg::opOr)
					result = a | b;
				else
					result = a ^ b;
				low = unsignedLess;
				negative = result[aluPkg::dataWidth-1];
				zero = result == '0;
			end
			default:
			begin
				result = ~a;
				negative = result[aluPkg::dataWidth-1];
				zero = result == '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/executeCore.sv ====
`default_nettype none

module executeCore
(
	input wire clk,
	input wire rst,
	input wire load,
	input wire [regPkg::regAddrWidth-1:0] loadAddr,
	input wire [aluPkg::dataWidth-1:0] loadData,
	input wire issue,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire [regPkg::regAddrWidth-1:0] srcA,
	input wire [regPkg::regAddrWidth-1:0] srcB,
	input wire [regPkg::regAddrWidth-1:0] dst,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic [aluPkg::dataWidth-1:0] high,
	output logic low,
	output logic negative,
	output logic zero,
	output logic done
);

	logic [aluPkg::dataWidth-1:0] operandA;
	logic [aluPkg::dataWidth-1:0] operandB;
	logic [aluPkg::dataWidth-1:0] aluResult;
	logic aluLow;
	logic aluNegative;
	logic aluZero;
	logic [aluPkg::dataWidth-1:0] shiftResult;
	logic [aluPkg::dataWidth-1:0] shiftHigh;
	logic shiftZero;
	logic writeEnable;
	logic [regPkg::regAddrWidth-1:0] writeAddr;
	logic [aluPkg::dataWidth-1:0] writeData;
	logic portEnable;
	logic [regPkg::regAddrWidth-1:0] portAddr;
	logic [aluPkg::dataWidth-1:0] portData;

	// External load beats writeback on the shared port
	assign portEnable = load || writeEnable;
	assign portAddr = load ? loadAddr : writeAddr;
	assign portData = load ? loadData : writeData;

	registerFile regFile
	(
		.clk(clk),
		.rst(rst),
		.writeEnable(portEnable),
		.writeAddr(portAddr),
		.writeData(portData),
		.readAddrA(srcA),
		.readAddrB(srcB),
		.readDataA(operandA),
		.readDataB(operandB)
	);

	// Both units see the same operands every cycle
	arithLogicUnit alu
	(
		.opcode(opcode),
		.a(operandA),
		.b(operandB),
		.result(aluResult),
		.low(aluLow),
		.negative(aluNegative),
		.zero(aluZero)
	);

	shiftMultiplyUnit shiftMul
	(
		.opcode(opcode),
		.a(operandA),
		.b(operandB),
		.result(shiftResult),
		.high(shiftHigh),
		.zero(shiftZero)
	);

	resultSelect select
	(
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.opcode(opcode),
		.dst(dst),
		.aluResult(aluResult),
		.aluLow(aluLow),
		.aluNegative(aluNegative),
		.aluZero(aluZero),
		.shiftResult(shiftResult),
		.shiftHigh(shiftHigh),
		.shiftZero(shiftZero),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.result(result),
		.high(high),
		.low(low),
		.negative(negative),
		.zero(zero),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== source/regPkg.sv ====
`default_nettype none

package regPkg;

	// Register file geometry
	localparam int regCount = 16;
	localparam int regAddrWidth = $clog2(regCount);

endpackage

`default_nettype wire

// ==== source/registerFile.sv ====
`default_nettype none

module registerFile
(
	input wire clk,
	input wire rst,
	input wire writeEnable,
	input wire [regPkg::regAddrWidth-1:0] writeAddr,
	input wire [aluPkg::dataWidth-1:0] writeData,
	input wire [regPkg::regAddrWidth-1:0] readAddrA,
	input wire [regPkg::regAddrWidth-1:0] readAddrB,
	output logic [aluPkg::dataWidth-1:0] readDataA,
	output logic [aluPkg::dataWidth-1:0] readDataB
);

	logic [aluPkg::dataWidth-1:0] regs [regPkg::regCount];

	// Single write port, all registers start at zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < regPkg::regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads are combinational
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// ==== source/resultSelect.sv ====
`default_nettype none

module resultSelect
(
	input wire clk,
	input wire rst,
	input wire issue,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire [regPkg::regAddrWidth-1:0] dst,
	input wire [aluPkg::dataWidth-1:0] aluResult,
	input wire aluLow,
	input wire aluNegative,
	input wire aluZero,
	input wire [aluPkg::dataWidth-1:0] shiftResult,
	input wire [aluPkg::dataWidth-1:0] shiftHigh,
	input wire shiftZero,
	output logic writeEnable,
	output logic [regPkg::regAddrWidth-1:0] writeAddr,
	output logic [aluPkg::dataWidth-1:0] writeData,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic [aluPkg::dataWidth-1:0] high,
	output logic low,
	output logic negative,
	output logic zero,
	output logic done
);

	logic useShift;
	logic illegal;
	logic isCompare;
	logic [aluPkg::dataWidth-1:0] nextResult;
	logic [aluPkg::dataWidth-1:0] nextHigh;
	logic [aluPkg::flagWidth-1:0] nextFlags;
	logic [aluPkg::flagWidth-1:0] flags;

	////////////////////////////////////////////////////////////////////////////
	// Decode and unit choice
	////////////////////////////////////////////////////////////////////////////

	assign useShift = opcode[aluPkg::opcodeWidth-1];
	assign illegal = opcode > aluPkg::opFmul;
	assign isCompare = (opcode == aluPkg::opCmp) || (opcode == aluPkg::opCmpr);

	always_comb
	begin
		nextResult = '0;
		nextHigh = '0;
		nextFlags = '0;
		if (!illegal && useShift)
		begin
			nextResult = shiftResult;
			nextHigh = shiftHigh;
			nextFlags[aluPkg::flagZero] = shiftZero;
		end
		else if (!illegal)
		begin
			nextResult = aluResult;
			nextFlags[aluPkg::flagLow] = aluLow;
			nextFlags[aluPkg::flagNegative] = aluNegative;
			nextFlags[aluPkg::flagZero] = aluZero;
		end
	end

	// Writeback lands on the issue edge itself
	assign writeEnable = issue && !isCompare && !illegal;
	assign writeAddr = dst;
	assign writeData = nextResult;

	////////////////////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done <= 1'b0;
			result <= '0;
			high <= '0;
			flags <= '0;
		end
		else
		begin
			done <= issue;
			// Hold everything until the next issue
			if (issue)
			begin
				result <= nextResult;
				high <= nextHigh;
				flags <= nextFlags;
			end
		end
	end

	assign low = flags[aluPkg::flagLow];
	assign negative = flags[aluPkg::flagNegative];
	assign zero = flags[aluPkg::flagZero];

endmodule

`default_nettype wire

// ==== source/shiftMultiplyUnit.sv ====
`default_nettype none

module shiftMultiplyUnit
(
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire [aluPkg::dataWidth-1:0] a,
	input wire [aluPkg::dataWidth-1:0] b,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic [aluPkg::dataWidth-1:0] high,
	output logic zero
);

	logic [aluPkg::opcodeWidth-1:0] unitOp;
	logic [aluPkg::shiftWidth-1:0] shiftAmount;
	logic [2*aluPkg::dataWidth-1:0] product;

	// This unit owns the upper half of the opcode space
	assign unitOp = {1'b1, opcode[aluPkg::funcWidth-1:0]};
	assign shiftAmount = a[aluPkg::shiftWidth-1:0];

	// One unsigned multiplier shared by MUL and FMUL
	assign product = a * b;

	always_comb
	begin
		result = '0;
		high = '0;
		zero = 1'b0;
		case (unitOp)
			aluPkg::opLsh:
				result = b << shiftAmount;
			aluPkg::opRsh:
				result = b >> shiftAmount;
			aluPkg::opArsh:
				result = $signed(b) >>> shiftAmount;
			aluPkg::opMul:
			begin
				high = product[2*aluPkg::dataWidth-1:aluPkg::dataWidth];
				result = product[aluPkg::dataWidth-1:0];
			end
			aluPkg::opFmul:
				result = product[aluPkg::fmulHigh:aluPkg::fmulLow];
			default:
				result = '0;
		endcase

		// Zero looks at the low half only, codes 13 to 15 report nothing
		if (unitOp <= aluPkg::opFmul)
			zero = result == '0;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/aluPkg.sv
source/regPkg.sv
source/registerFile.sv
source/arithLogicUnit.sv
source/shiftMultiplyUnit.sv
source/resultSelect.sv
source/executeCore.sv
test/executeCore_assert.sv
test/executeCore_tb.sv

// ==== test/executeCore_assert.sv ====
`default_nettype none

module executeCore_assert
(
	input wire clk,
	input wire rst,
	input wire issue,
	input wire [aluPkg::opcodeWidth-1:0] opcode,
	input wire writeEnable,
	input wire [aluPkg::dataWidth-1:0] result,
	input wire [aluPkg::dataWidth-1:0] high,
	input wire low,
	input wire negative,
	input wire zero,
	input wire done
);

	logic noWrite;

	// Failure counts per property
	int doneFailures = 0;
	int writeFailures = 0;
	int resetFailures = 0;

	// Compares and codes 13 to 15 never touch the register file
	assign noWrite = (opcode == aluPkg::opCmp) || (opcode == aluPkg::opCmpr)
		|| (opcode > aluPkg::opFmul);

	// done only stays up when another issue follows
	donePulse: assert property (@(posedge clk) disable iff (rst) !issue |=> !done)
	else
	begin
		doneFailures++;
		$error("done held high without a new issue");
	end

	noWriteback: assert property (@(posedge clk) disable iff (rst) noWrite |-> !writeEnable)
	else
	begin
		writeFailures++;
		$error("writeback enabled for a compare or illegal opcode");
	end

	resetClears: assert property (@(posedge clk)
		rst |=> (result == '0 && high == '0 && !low && !negative && !zero && !done))
	else
	begin
		resetFailures++;
		$error("outputs not cleared after reset");
	end

endmodule

bind executeCore executeCore_assert checks
(
	.clk(clk),
	.rst(rst),
	.issue(issue),
	.opcode(opcode),
	.writeEnable(writeEnable),
	.result(result),
	.high(high),
	.low(low),
	.negative(negative),
	.zero(zero),
	.done(done)
);

`default_nettype wire

// ==== test/executeCore_tb.sv ====
`default_nettype none

module executeCore_tb;

	localparam int doneTimeout = 20;

	logic clk;
	logic rst;
	logic load;
	logic [3:0] loadAddr;
	logic [15:0] loadData;
	logic issue;
	logic [3:0] opcode;
	logic [3:0] srcA;
	logic [3:0] srcB;
	logic [3:0] dst;
	logic [15:0] result;
	logic [15:0] high;
	logic low;
	logic negative;
	logic zero;
	logic done;

	// Expected register contents and the pending operation
	logic [15:0] shadow [16];
	logic [15:0] expResult;
	logic [15:0] expHigh;
	logic [15:0] expFlags;
	logic expWrite;
	logic [3:0] expDst;
	string testName;

	executeCore uut
	(
		.clk(clk),
		.rst(rst),
		.load(load),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.issue(issue),
		.opcode(opcode),
		.srcA(srcA),
		.srcB(srcB),
		.dst(dst),
		.result(result),
		.high(high),
		.low(low),
		.negative(negative),
		.zero(zero),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	// Flags packed as {low, negative, zero}
	function automatic void modelOp(input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b, output logic [15:0] res, output logic [15:0] hi,
		output logic [15:0] flags, output logic wr);
		logic [31:0] prod;
		logic lo;
		logic ng;
		logic zr;
		prod = {16'b0, a} * {16'b0, b};
		res = '0;
		hi = '0;
		lo = 1'b0;
		ng = 1'b0;
		zr = 1'b0;
		wr = 1'b1;
		case (op)
			aluPkg::opAdd, aluPkg::opSub:
			begin
				res = (op == aluPkg::opAdd) ? a + b : a - b;
				lo = $signed(a) < $signed(b);
				ng = res[15];
				zr = (op == aluPkg::opAdd) ? (res == 16'd0) : (a == b);
			end
			aluPkg::opCmp, aluPkg::opCmpr:
			begin
				lo = (op == aluPkg::opCmp) ? (a < b) : (b < a);
				ng = (op == aluPkg::opCmp) ? ($signed(a) < $signed(b))
					: ($signed(b) < $signed(a));
				zr = a == b;
				wr = 1'b0;
			end
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor:
			begin
				if (op == aluPkg::opAnd)
					res = a & b;
				else if (op == aluPkg::opOr)
					res = a | b;
				else
					res = a ^ b;
				lo = a < b;
				ng = res[15];
				zr = res == 16'd0;
			end
			aluPkg::opNot:
			begin
				res = ~a;
				ng = res[15];
				zr = res == 16'd0;
			end
			aluPkg::opLsh, aluPkg::opRsh, aluPkg::opArsh:
			begin
				if (op == aluPkg::opLsh)
					res = b << a[3:0];
				else if (op == aluPkg::opRsh)
					res = b >> a[3:0];
				else
					res = $signed(b) >>> a[3:0];
				zr = res == 16'd0;
			end
			aluPkg::opMul:
			begin
				hi = prod[31:16];
				res = prod[15:0];
				zr = res == 16'd0;
			end
			aluPkg::opFmul:
			begin
				res = prod[29:14];
				zr = res == 16'd0;
			end
			default:
				wr = 1'b0;
		endcase
		flags = {13'b0, lo, ng, zr};
	endfunction

	task automatic check(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual)
		begin
			$display("Error in %s (%s): expected %h, actual %h", testName, what,
				expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic waitDone(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!done && cycles < doneTimeout);
		if (!done)
		begin
			$display("Timeout in %s: done never arrived after %0d cycles", testName, cycles);
			$display("*** FAILED ***");
			$fatal(1, "Timeout");
		end
	endtask

	// Called on a falling edge, leaves the load strobe low on the next one
	task automatic loadReg(input logic [3:0] addr, input logic [15:0] data);
		load = 1'b1;
		loadAddr = addr;
		loadData = data;
		@(negedge clk);
		load = 1'b0;
		shadow[addr] = data;
	endtask

	task automatic startOp(input logic [3:0] op, input logic [3:0] sa,
		input logic [3:0] sb, input logic [3:0] d);
		modelOp(op, shadow[sa], shadow[sb], expResult, expHigh, expFlags, expWrite);
		expDst = d;
		opcode = op;
		srcA = sa;
		srcB = sb;
		dst = d;
		issue = 1'b1;
	endtask

	task automatic finishOp();
		int cycles;
		waitDone(cycles);
		check("done latency", 16'd1, 16'(cycles));
		check("result", expResult, result);
		check("high", expHigh, high);
		check("flags low negative zero", expFlags, {13'b0, low, negative, zero});
		if (expWrite)
			shadow[expDst] = expResult;
	endtask

	task automatic runOp(input logic [3:0] op, input logic [3:0] sa,
		input logic [3:0] sb, input logic [3:0] d);
		startOp(op, sa, sb, d);
		finishOp();
		issue = 1'b0;
	endtask

	// Reads a register through ADD with r0, scratch result in r15
	task automatic checkReg(input logic [3:0] addr, input logic [15:0] expected);
		runOp(aluPkg::opAdd, addr, 4'd0, 4'd15);
		check("register value", expected, result);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testReset();
		testName = "reset";
		check("done", 16'd0, {15'b0, done});
		check("result", 16'd0, result);
		check("high", 16'd0, high);
		check("flags", 16'd0, {13'b0, low, negative, zero});
		runOp(aluPkg::opAdd, 4'd1, 4'd2, 4'd3);
		check("zero flag", 16'd1, {15'b0, zero});
	endtask

	task automatic testArithLogic();
		logic [15:0] edgeA [4];
		logic [15:0] edgeB [4];
		logic [3:0] ops [6];
		logic [15:0] a;
		logic [15:0] b;
		edgeA = '{16'h7fff, 16'h8000, 16'hffff, 16'h0000};
		edgeB = '{16'h8000, 16'h7fff, 16'h0001, 16'h0000};
		ops = '{aluPkg::opAdd, aluPkg::opSub, aluPkg::opAnd, aluPkg::opOr,
			aluPkg::opXor, aluPkg::opNot};
		testName = "arith logic";
		for (int i = 0; i < 24; i++)
		begin
			a = (i < 4) ? edgeA[i] : 16'($urandom);
			b = (i < 4) ? edgeB[i] : 16'($urandom);
			loadReg(4'd1, a);
			loadReg(4'd2, b);
			for (int k = 0; k < 6; k++)
			begin
				runOp(ops[k], 4'd1, 4'd2, 4'd3);
			end
		end
	endtask

	task automatic testCompares();
		logic [15:0] pairA [4];
		logic [15:0] pairB [4];
		// Equal, less, greater, and signed against unsigned
		pairA = '{16'h1234, 16'h0001, 16'h0005, 16'hfff0};
		pairB = '{16'h1234, 16'h0002, 16'h0003, 16'h0010};
		testName = "compares";
		loadReg(4'd6, 16'hbeef);
		for (int i = 0; i < 4; i++)
		begin
			loadReg(4'd4, pairA[i]);
			loadReg(4'd5, pairB[i]);
			runOp(aluPkg::opCmp, 4'd4, 4'd5, 4'd6);
			runOp(aluPkg::opCmpr, 4'd4, 4'd5, 4'd6);
			checkReg(4'd6, 16'hbeef);
		end
	endtask

	task automatic testShifts();
		logic [3:0] fixedCounts [3];
		logic [15:0] fixA [3];
		logic [15:0] fixB [3];
		logic [15:0] fixExpect [3];
		logic [3:0] count;
		logic [15:0] a;
		logic [15:0] b;
		fixedCounts = '{4'd0, 4'd1, 4'd15};
		// Q2.14 pairs 1.0 x 1.5, 0.5 x 0.5, 1.5 x 1.5
		fixA = '{16'h4000, 16'h2000, 16'h6000};
		fixB = '{16'h6000, 16'h2000, 16'h6000};
		fixExpect = '{16'h6000, 16'h1000, 16'h9000};
		testName = "shifts and products";
		for (int i = 0; i < 8; i++)
		begin
			count = (i < 3) ? fixedCounts[i] : 4'($urandom);
			a = {12'($urandom), count};
			// Negative B for the fixed counts so ARSH and RSH differ
			b = 16'($urandom) | ((i < 3) ? 16'h8000 : 16'h0000);
			loadReg(4'd7, a);
			loadReg(4'd8, b);
			runOp(aluPkg::opLsh, 4'd7, 4'd8, 4'd9);
			runOp(aluPkg::opRsh, 4'd7, 4'd8, 4'd9);
			runOp(aluPkg::opArsh, 4'd7, 4'd8, 4'd9);
		end
		for (int i = 0; i < 6; i++)
		begin
			a = (i == 0) ? 16'hffff : 16'($urandom);
			b = (i == 0) ? 16'hffff : 16'($urandom);
			loadReg(4'd7, a);
			loadReg(4'd8, b);
			runOp(aluPkg::opMul, 4'd7, 4'd8, 4'd9);
			runOp(aluPkg::opFmul, 4'd7, 4'd8, 4'd9);
		end
		for (int i = 0; i < 3; i++)
		begin
			loadReg(4'd7, fixA[i]);
			loadReg(4'd8, fixB[i]);
			runOp(aluPkg::opFmul, 4'd7, 4'd8, 4'd9);
			check("fixed-point product", fixExpect[i], result);
		end
	endtask

	task automatic testChaining();
		testName = "writeback chain";
		loadReg(4'd1, 16'($urandom));
		loadReg(4'd2, 16'($urandom));
		// Each op reads the previous destination on the very next cycle
		startOp(aluPkg::opAdd, 4'd1, 4'd2, 4'd9);
		finishOp();
		startOp(aluPkg::opSub, 4'd9, 4'd1, 4'd10);
		finishOp();
		startOp(aluPkg::opXor, 4'd10, 4'd9, 4'd11);
		finishOp();
		issue = 1'b0;

		testName = "load over writeback";
		load = 1'b1;
		loadAddr = 4'd11;
		loadData = 16'h5a5a;
		startOp(aluPkg::opAdd, 4'd1, 4'd2, 4'd11);
		finishOp();
		load = 1'b0;
		issue = 1'b0;
		shadow[11] = 16'h5a5a;
		checkReg(4'd11, 16'h5a5a);
	endtask

	task automatic testIllegal();
		testName = "illegal opcodes";
		loadReg(4'd1, 16'hffff);
		loadReg(4'd2, 16'h8001);
		loadReg(4'd12, 16'h0f0f);
		for (int c = 13; c <= 15; c++)
		begin
			// Nonzero result and high left behind
			runOp(aluPkg::opMul, 4'd1, 4'd2, 4'd13);
			runOp(4'(c), 4'd1, 4'd2, 4'd12);
			// Low and negative left behind
			runOp(aluPkg::opCmpr, 4'd1, 4'd2, 4'd13);
			runOp(4'(c), 4'd1, 4'd2, 4'd12);
			// Zero left behind
			runOp(aluPkg::opCmp, 4'd1, 4'd1, 4'd13);
			runOp(4'(c), 4'd1, 4'd2, 4'd12);
			checkReg(4'd12, 16'h0f0f);
		end
	endtask

	initial
	begin
		void'($urandom(63));
		rst = 1'b1;
		load = 1'b0;
		loadAddr = '0;
		loadData = '0;
		issue = 1'b0;
		opcode = '0;
		srcA = '0;
		srcB = '0;
		dst = '0;
		testName = "startup";
		for (int i = 0; i < 16; i++)
		begin
			shadow[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		testReset();
		testArithLogic();
		testCompares();
		testShifts();
		testChaining();
		testIllegal();

		if (uut.checks.doneFailures + uut.checks.writeFailures
			+ uut.checks.resetFailures == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
		begin
			$display("*** FAILED ***");
			$fatal(1, "Bound assertions failed");
		end
	end

endmodule

`default_nettype wire
